// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module stcModBench -o stcModBench

# Passes only when the bench prints its pass line
run: compile
	@out="$$(./obj_dir/stcModBench)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: bench/stcModTasks.svh
`ifndef STC_MOD_TASKS_SVH
`define STC_MOD_TASKS_SVH

//****************************************************************************
// Host access and checks
//****************************************************************************
task automatic writeReg(input regAddr_t addr, input logic [31:0] data);
    @(posedge clk);
    regWrite     <= 1'b1;
    regAddr      <= addr;
    regWriteData <= data;
    @(posedge clk);                     // Write lands here
    regWrite     <= 1'b0;
endtask

task automatic readCheck(input string testName, input regAddr_t addr,
                         input logic [31:0] expected);
    logic [31:0] actual;
    @(posedge clk);
    regAddr <= addr;
    @(posedge clk);
    actual = regReadData;
    checkCount++;
    assert (actual == expected) else begin
        errorCount++;
        $display("Fail %s reg %0d: expected %h, actual %h", testName, addr, expected, actual);
    end
endtask

task automatic checkDac(input string testName, input string dacName,
                        input logic [13:0] expected, input logic [13:0] actual);
    checkCount++;
    assert (actual == expected) else begin
        errorCount++;
        $display("Fail %s %s: expected %h, actual %h", testName, dacName, expected, actual);
    end
endtask

function automatic logic [31:0] fieldMask(input int addr);
    case (addr)
        1:             return 32'h1;
        2:             return 32'hFF_FFFF;
        3:             return 32'h1F;
        4, 5, 6, 7, 8: return 32'h3_FFFF;
        default:       return 32'hF;    // Source codes
    endcase
endfunction

task automatic configurePn(input logic [23:0] taps, input logic [4:0] len);
    writeReg(regPnTaps, 32'(taps));
    writeReg(regPnLength, 32'(len));
    modelTaps   = taps;
    modelLength = len;
endtask

task automatic setGains(input sample_t dev, input complexSample_t g0, input complexSample_t g1);
    writeReg(regDeviation, 32'(dev));
    writeReg(regH0Real, 32'(g0.re));
    writeReg(regH0Imag, 32'(g0.im));
    writeReg(regH1Real, 32'(g1.re));
    writeReg(regH1Imag, 32'(g1.im));
    modelDev = dev;
    modelH0  = g0;
    modelH1  = g1;
endtask

task automatic setSources(input logic [3:0] code0, input logic [3:0] code1);
    writeReg(regDac0Source, 32'(code0));
    writeReg(regDac1Source, 32'(code1));
endtask

task automatic startTx();
    writeReg(regControl, 32'd1);
    pnState = '1;                       // LFSR restarts from all ones
endtask

task automatic stopTx();
    writeReg(regControl, 32'd0);
endtask

function automatic complexSample_t randomGain();
    complexSample_t g;
    g.re = 18'($urandom);
    g.im = 18'($urandom);
    return g;
endfunction

// Sample each pair 6 clocks after its second bit tick
task automatic runPairs(input string testName, input int pairs, input int mode);
    logic           b0;
    logic           b1;
    logic [13:0]    e0;
    logic [13:0]    e1;
    sample_t        c0Re;
    sample_t        c0Im;
    sample_t        c1Re;
    sample_t        c1Im;
    for (int i = 0; i < pairs; i++) begin
        nextPair(b0, b1);
        c0Re = scaledPart(nrzOf(b0), modelH0.re);
        c0Im = scaledPart(nrzOf(b0), modelH0.im);
        c1Re = scaledPart(nrzOf(b1), modelH1.re);
        c1Im = scaledPart(nrzOf(b1), modelH1.im);
        case (mode)
            ModePoly: begin
                e0 = b0 ? 14'h3000 : 14'h2000;
                e1 = b1 ? 14'h3000 : 14'h2000;
            end
            ModeCh0: begin
                e0 = dacWord(c0Re);
                e1 = dacWord(c0Im);
            end
            ModeTx: begin
                e0 = dacWord(c0Re + c1Re);      // Wraps at 18 bits
                e1 = dacWord(c0Im + c1Im);
            end
            ModeFmSwap: begin
                e0 = dacWord(nrzOf(b1));
                e1 = dacWord(nrzOf(b0));
            end
            default: begin
                e0 = dacWord(nrzOf(b0));
                e1 = dacWord(nrzOf(b1));
            end
        endcase
        repeat ((i == 0) ? 2 * BitPeriod + 6 : 2 * BitPeriod) @(posedge clk);
        checkDac(testName, "dac0", e0, dac0);
        checkDac(testName, "dac1", e1, dac1);
    end
endtask

//****************************************************************************
// Directed tests
//****************************************************************************
task automatic resetState();
    logic [31:0] expected [0:10];
    expected = '{32'd539, 32'h0, 32'h60, 32'h7, 32'h8000, 32'h1FFFF,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    for (int a = 0; a <= 10; a++)
        readCheck("resetState", regAddr_t'(4'(a)), expected[a]);
    checkDac("resetState", "dac0", 14'h2000, dac0);
    checkDac("resetState", "dac1", 14'h2000, dac1);
endtask

task automatic registerAccess();
    logic [31:0] written [1:10];
    for (int a = 1; a <= 10; a++) begin
        written[a] = $urandom;
        if (a == 1)
            written[a][0] = 1'b0;       // Stay disabled with a random length
        writeReg(regAddr_t'(4'(a)), written[a]);
    end
    for (int a = 1; a <= 10; a++)
        readCheck("registerAccess", regAddr_t'(4'(a)), written[a] & fieldMask(a));
    writeReg(regVersion, $urandom);
    readCheck("registerAccess", regVersion, 32'd539);
    for (int a = 11; a <= 15; a++)
        readCheck("registerAccess", regAddr_t'(4'(a)), 32'h0);
    configurePn(24'h60, 5'd7);
    writeReg(regControl, $urandom | 32'h1);
    readCheck("registerAccess", regControl, 32'h1);
    stopTx();
    readCheck("registerAccess", regControl, 32'h0);
endtask

task automatic pnSequence();
    logic [4:0]  len;
    logic [23:0] taps;
    setSources(srcPoly, srcPoly);
    configurePn(24'h60, 5'd7);
    startTx();
    runPairs("pnSequence", 40, ModePoly);
    stopTx();
    len  = 5'(8 + $urandom % 17);
    taps = (24'($urandom) & 24'((25'h1 << len) - 25'h1)) | (24'h1 << (len - 5'd1));
    configurePn(taps, len);
    startTx();
    runPairs("pnSequence", 40, ModePoly);
    stopTx();
endtask

task automatic channelGain();
    configurePn(24'h60, 5'd7);
    setGains(18'($urandom), randomGain(), randomGain());
    setSources(srcCh0I, srcCh0Q);
    startTx();
    runPairs("channelGain", 20, ModeCh0);
    stopTx();
endtask

task automatic combining();
    setGains(18'($urandom), randomGain(), randomGain());
    setSources(srcTxI, srcTxQ);
    startTx();
    runPairs("combining", 20, ModeTx);
    stopTx();
    setSources(srcCh1Fm, 4'd12);        // 12 is an undefined code
    startTx();
    runPairs("combining", 10, ModeFmSwap);
    stopTx();
endtask

task automatic enableGate();
    setSources(srcCh0Fm, srcCh1Fm);
    startTx();
    runPairs("enableGate", 5, ModeLevels);
    stopTx();
    repeat (6) @(posedge clk);
    checkDac("enableGate", "dac0", 14'h2000, dac0);
    checkDac("enableGate", "dac1", 14'h2000, dac1);
    startTx();
    runPairs("enableGate", 10, ModeLevels);
    stopTx();
endtask

`endif

// File: bench/stcModBench.sv
`timescale 1ns/1ps

module stcModBench;

    import stcPkg::*;

    localparam int          BitPeriod  = 8;
    localparam logic [31:0] Seed       = 32'he19f_ecff;
    localparam int          TotalPairs = 145;           // Sum over all tests
    localparam int          TimeoutNs  = 2 * (TotalPairs + 20) * 2 * BitPeriod * 40;

    // Expected-word selections for runPairs
    localparam int ModePoly   = 0;
    localparam int ModeCh0    = 1;
    localparam int ModeTx     = 2;
    localparam int ModeFmSwap = 3;  // DAC 0 on channel 1 level and DAC 1 on channel 0 level
    localparam int ModeLevels = 4;

    logic                  clk;
    logic                  reset;
    logic                  regWrite;
    regAddr_t              regAddr;
    logic [DataWidth-1:0]  regWriteData;
    logic [DataWidth-1:0]  regReadData;
    logic [DacWidth-1:0]   dac0;
    logic [DacWidth-1:0]   dac1;

    int errorCount = 0;
    int checkCount = 0;

    //**************************************************************************
    // PN and channel reference model
    //**************************************************************************
    logic [MaxPnLength-1:0] pnState;
    logic [MaxPnLength-1:0] modelTaps;
    logic [4:0]             modelLength;
    sample_t                modelDev;
    complexSample_t         modelH0;
    complexSample_t         modelH1;

    task automatic stepModel(output logic bitOut);
        logic [MaxPnLength-1:0] keep;
        logic                   feedback;
        keep     = MaxPnLength'((25'h1 << modelLength) - 25'h1);
        bitOut   = pnState[modelLength - 5'd1];
        feedback = ^(pnState & modelTaps);
        pnState  = {pnState[MaxPnLength-2:0], feedback} & keep;
    endtask

    task automatic nextPair(output logic b0, output logic b1);
        stepModel(b0);                  // First tick of the pair
        stepModel(b1);
    endtask

    function automatic sample_t nrzOf(input logic b);
        return b ? modelDev : -modelDev;
    endfunction

    // Q1.17 product keeps bits 34..17
    function automatic sample_t scaledPart(input sample_t lvl, input sample_t g);
        logic signed [2*SampleWidth-1:0] prod;
        prod = 36'(lvl) * 36'(g);
        return prod[34:17];
    endfunction

    function automatic logic [DacWidth-1:0] dacWord(input sample_t s);
        return {~s[17], s[16:4]};       // Offset binary
    endfunction

    `include "stcModTasks.svh"

    stcModTop #(.VersionNumber(16'd539), .BitPeriod(BitPeriod)) uut (
        .clk(clk), .reset(reset),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .regReadData(regReadData),
        .dac0(dac0), .dac1(dac1)
    );

    always #20 clk = ~clk;

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        regWrite     = 1'b0;
        regAddr      = regVersion;
        regWriteData = '0;
        void'($urandom(Seed));
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        resetState();
        registerAccess();
        pnSequence();
        channelGain();
        combining();
        enableGate();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        $display("Watchdog: the tests did not finish within %0d ns", TimeoutNs);
        $display("Errors found");
        $finish;
    end

endmodule

// File: list.f
+incdir+bench
logic/stcPkg.sv
logic/stcRegs.sv
logic/pnFramer.sv
logic/channelPath.sv
logic/dacCombiner.sv
logic/stcModTop.sv
bench/stcModBench.sv

// File: logic/channelPath.sv
`timescale 1ns/1ps

module channelPath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    payloadBit,
    input  logic                    pairActive,
    input  stcPkg::sample_t         deviation,
    input  stcPkg::complexSample_t  gain,
    output stcPkg::sample_t         level,
    output stcPkg::complexSample_t  channelOut
);

    import stcPkg::*;

    sample_t                         nrzLevel;
    logic signed [2*SampleWidth-1:0] productRe;
    logic signed [2*SampleWidth-1:0] productIm;

    //**************************************************************************
    // NRZ mapping
    //**************************************************************************
    always_comb begin
        if (!pairActive) begin
            nrzLevel = '0;                  // Idle between enables
        end
        else if (payloadBit) begin
            nrzLevel = deviation;
        end
        else begin
            nrzLevel = -deviation;
        end
    end

    // Q1.17 gain keeps the product aligned to the level
    assign productRe = nrzLevel * gain.re;
    assign productIm = nrzLevel * gain.im;

    always_ff @(posedge clk) begin
        if (reset) begin
            level      <= '0;
            channelOut <= '0;
        end
        else begin
            level         <= nrzLevel;      // FM source value
            channelOut.re <= productRe[2*SampleWidth-2:SampleWidth-1];
            channelOut.im <= productIm[2*SampleWidth-2:SampleWidth-1];
        end
    end

endmodule

// File: logic/dacCombiner.sv
`timescale 1ns/1ps

module dacCombiner (
    input  logic                         clk,
    input  logic                         reset,
    input  stcPkg::stcConfig_t           cfg,
    input  stcPkg::bitPair_t             pair,
    input  stcPkg::sample_t              level0,
    input  stcPkg::sample_t              level1,
    input  stcPkg::complexSample_t       ch0,
    input  stcPkg::complexSample_t       ch1,
    output logic [stcPkg::DacWidth-1:0]  dac0,
    output logic [stcPkg::DacWidth-1:0]  dac1
);

    import stcPkg::*;

    localparam logic [DacWidth-1:0] DacMidScale = {1'b1, {(DacWidth-1){1'b0}}};

    sample_t  txI;
    sample_t  txQ;
    bitPair_t pairDelay;    // Lines the PN bits up with the channel outputs
    sample_t  select0;
    sample_t  select1;

    // Sum of both channels wraps at 18 bits
    assign txI = ch0.re + ch1.re;
    assign txQ = ch0.im + ch1.im;

    function automatic sample_t pickSource(input dacSource_t src, input logic polyBit);
        case (src)
            srcCh0Fm: return level0;
            srcCh0I:  return ch0.re;
            srcCh0Q:  return ch0.im;
            srcCh1Fm: return level1;
            srcCh1I:  return ch1.re;
            srcCh1Q:  return ch1.im;
            srcTxI:   return txI;
            srcTxQ:   return txQ;
            srcPoly:  return polyBit ? PolyLevel : '0;
            default:  return level0;        // Undefined codes
        endcase
    endfunction

    // Drop the bits below the DAC and flip the sign into offset binary
    function automatic logic [DacWidth-1:0] offsetBinary(input sample_t s);
        return {~s[SampleWidth-1], s[SampleWidth-2:SampleWidth-DacWidth]};
    endfunction

    //**************************************************************************
    // Source selectors and DAC words
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pairDelay <= '0;
            select0   <= '0;
            select1   <= '0;
        end
        else begin
            pairDelay <= pair;
            select0   <= pickSource(cfg.dac0Source, pairDelay.bit0);
            select1   <= pickSource(cfg.dac1Source, pairDelay.bit1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dac0 <= DacMidScale;
            dac1 <= DacMidScale;
        end
        else begin
            dac0 <= offsetBinary(select0);
            dac1 <= offsetBinary(select1);
        end
    end

    assert property (@(posedge clk)
        $fell(reset) |=> (dac0 == DacMidScale && dac1 == DacMidScale))
        else $error("dacCombiner: DAC outputs not at mid scale after reset");

endmodule

// File: logic/pnFramer.sv
`timescale 1ns/1ps

module pnFramer #(
    parameter int BitPeriod = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             txEnable,
    input  logic [stcPkg::MaxPnLength-1:0]   pnTaps,
    input  logic [4:0]                       pnLength,
    output stcPkg::bitPair_t                 pair,
    output logic                             pairActive
);

    import stcPkg::*;

    localparam int CountWidth = $clog2(BitPeriod + 1);

    logic [CountWidth-1:0]  tickCount;
    logic                   bitTick;
    logic [MaxPnLength-1:0] lfsr;
    logic [MaxPnLength-1:0] lengthMask;
    logic                   pnBit;
    logic                   parity;
    logic                   secondBit;      // Next tick completes a pair
    logic                   heldBit;

    //**************************************************************************
    // Bit tick
    //**************************************************************************
    assign bitTick = txEnable && (tickCount == CountWidth'(BitPeriod - 1));

    always_ff @(posedge clk) begin
        if (reset || !txEnable) begin
            tickCount <= '0;
        end
        else if (bitTick) begin
            tickCount <= '0;
        end
        else begin
            tickCount <= tickCount + 1'b1;
        end
    end

    //**************************************************************************
    // Programmable LFSR
    //**************************************************************************
    assign pnBit      = lfsr[pnLength - 5'd1];              // Output tap
    assign parity     = ^(lfsr & pnTaps);
    assign lengthMask = ~({MaxPnLength{1'b1}} << pnLength); // Bits below length

    always_ff @(posedge clk) begin
        if (reset || !txEnable) begin
            lfsr <= '1;
        end
        else if (bitTick) begin
            lfsr <= {lfsr[MaxPnLength-2:0], parity} & lengthMask;
        end
    end

    // Odd ticks hold their bit, even ticks publish the pair
    always_ff @(posedge clk) begin
        if (bitTick && !secondBit) begin
            heldBit <= pnBit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !txEnable) begin
            secondBit  <= 1'b0;
            pair       <= '0;
            pairActive <= 1'b0;
        end
        else if (bitTick) begin
            secondBit <= !secondBit;
            if (secondBit) begin
                pair       <= '{bit0: heldBit, bit1: pnBit};
                pairActive <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        txEnable |-> (pnLength >= 5'd2 && pnLength <= 5'(MaxPnLength)))
        else $error("pnFramer: PN length out of range");

endmodule

// File: logic/stcModTop.sv
`timescale 1ns/1ps

module stcModTop #(
    parameter logic [15:0] VersionNumber = 16'd539,
    parameter int          BitPeriod     = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           regWrite,
    input  stcPkg::regAddr_t               regAddr,
    input  logic [stcPkg::DataWidth-1:0]   regWriteData,
    output logic [stcPkg::DataWidth-1:0]   regReadData,
    output logic [stcPkg::DacWidth-1:0]    dac0,
    output logic [stcPkg::DacWidth-1:0]    dac1
);

    import stcPkg::*;

    stcConfig_t     cfg;
    bitPair_t       pair;
    logic           pairActive;
    sample_t        level0;
    sample_t        level1;
    complexSample_t ch0;
    complexSample_t ch1;

    //**************************************************************************
    // Host registers
    //**************************************************************************
    stcRegs #(.VersionNumber(VersionNumber)) regs (
        .clk(clk), .reset(reset),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .regReadData(regReadData),
        .cfg(cfg)
    );

    //**************************************************************************
    // PN source and two channel paths
    //**************************************************************************
    pnFramer #(.BitPeriod(BitPeriod)) framer (
        .clk(clk), .reset(reset),
        .txEnable(cfg.txEnable),
        .pnTaps(cfg.pnTaps),
        .pnLength(cfg.pnLength),
        .pair(pair),
        .pairActive(pairActive)
    );

    channelPath chPath0 (
        .clk(clk), .reset(reset),
        .payloadBit(pair.bit0),
        .pairActive(pairActive),
        .deviation(cfg.deviation),
        .gain(cfg.h0),
        .level(level0),
        .channelOut(ch0)
    );

    channelPath chPath1 (
        .clk(clk), .reset(reset),
        .payloadBit(pair.bit1),
        .pairActive(pairActive),
        .deviation(cfg.deviation),
        .gain(cfg.h1),
        .level(level1),
        .channelOut(ch1)
    );

    dacCombiner combiner (
        .clk(clk), .reset(reset),
        .cfg(cfg),
        .pair(pair),
        .level0(level0), .level1(level1),
        .ch0(ch0), .ch1(ch1),
        .dac0(dac0), .dac1(dac1)
    );

endmodule

// File: logic/stcPkg.sv
package stcPkg;

    //**************************************************************************
    // Widths
    //**************************************************************************
    localparam int SampleWidth = 18;
    localparam int DacWidth    = 14;
    localparam int MaxPnLength = 24;
    localparam int AddrWidth   = 4;
    localparam int DataWidth   = 32;

    typedef logic signed [SampleWidth-1:0] sample_t;    // Gains are Q1.17

    typedef struct packed {
        sample_t re;
        sample_t im;
    } complexSample_t;

    // First and second bit of a PN pair
    typedef struct packed {
        logic bit0;
        logic bit1;
    } bitPair_t;

    //**************************************************************************
    // DAC source codes and register map
    //**************************************************************************
    typedef enum logic [3:0] {
        srcCh0Fm = 4'd0,
        srcCh0I  = 4'd1,
        srcCh0Q  = 4'd2,
        srcCh1Fm = 4'd3,
        srcCh1I  = 4'd4,
        srcCh1Q  = 4'd5,
        srcTxI   = 4'd6,
        srcTxQ   = 4'd7,
        srcPoly  = 4'd8
    } dacSource_t;

    typedef enum logic [AddrWidth-1:0] {
        regVersion    = 4'd0,
        regControl    = 4'd1,
        regPnTaps     = 4'd2,
        regPnLength   = 4'd3,
        regDeviation  = 4'd4,
        regH0Real     = 4'd5,
        regH0Imag     = 4'd6,
        regH1Real     = 4'd7,
        regH1Imag     = 4'd8,
        regDac0Source = 4'd9,
        regDac1Source = 4'd10
    } regAddr_t;

    // Everything the host can set
    typedef struct packed {
        logic                   txEnable;
        logic [MaxPnLength-1:0] pnTaps;
        logic [4:0]             pnLength;
        sample_t                deviation;  // NRZ peak
        complexSample_t         h0;
        complexSample_t         h1;
        dacSource_t             dac0Source;
        dacSource_t             dac1Source;
    } stcConfig_t;

    localparam sample_t PolyLevel = 18'sh10000;     // Set bit on srcPoly

endpackage

// File: logic/stcRegs.sv
`timescale 1ns/1ps

module stcRegs #(
    parameter logic [15:0] VersionNumber = 16'd539
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           regWrite,
    input  stcPkg::regAddr_t               regAddr,
    input  logic [stcPkg::DataWidth-1:0]   regWriteData,
    output logic [stcPkg::DataWidth-1:0]   regReadData,
    output stcPkg::stcConfig_t             cfg
);

    import stcPkg::*;

    localparam stcConfig_t ResetConfig = '{
        txEnable:   1'b0,
        pnTaps:     24'h000060,
        pnLength:   5'd7,
        deviation:  18'sh08000,
        h0:         '{re: 18'sh1FFFF, im: 18'sh00000},
        h1:         '{re: 18'sh00000, im: 18'sh00000},
        dac0Source: srcCh0Fm,
        dac1Source: srcCh0Fm
    };

    //**************************************************************************
    // Write decode
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= ResetConfig;
        end
        else if (regWrite) begin
            case (regAddr)
                regControl:    cfg.txEnable   <= regWriteData[0];
                regPnTaps:     cfg.pnTaps     <= regWriteData[MaxPnLength-1:0];
                regPnLength:   cfg.pnLength   <= regWriteData[4:0];
                regDeviation:  cfg.deviation  <= regWriteData[SampleWidth-1:0];
                regH0Real:     cfg.h0.re      <= regWriteData[SampleWidth-1:0];
                regH0Imag:     cfg.h0.im      <= regWriteData[SampleWidth-1:0];
                regH1Real:     cfg.h1.re      <= regWriteData[SampleWidth-1:0];
                regH1Imag:     cfg.h1.im      <= regWriteData[SampleWidth-1:0];
                regDac0Source: cfg.dac0Source <= dacSource_t'(regWriteData[3:0]);
                regDac1Source: cfg.dac1Source <= dacSource_t'(regWriteData[3:0]);
                default: ;                  // Version is read only
            endcase
        end
    end

    //**************************************************************************
    // Readback mux
    //**************************************************************************
    // Part selects keep the signed fields from sign extending
    always_comb begin
        regReadData = '0;
        case (regAddr)
            regVersion:    regReadData = DataWidth'(VersionNumber);
            regControl:    regReadData = DataWidth'(cfg.txEnable);
            regPnTaps:     regReadData = DataWidth'(cfg.pnTaps);
            regPnLength:   regReadData = DataWidth'(cfg.pnLength);
            regDeviation:  regReadData = DataWidth'(cfg.deviation[SampleWidth-1:0]);
            regH0Real:     regReadData = DataWidth'(cfg.h0.re[SampleWidth-1:0]);
            regH0Imag:     regReadData = DataWidth'(cfg.h0.im[SampleWidth-1:0]);
            regH1Real:     regReadData = DataWidth'(cfg.h1.re[SampleWidth-1:0]);
            regH1Imag:     regReadData = DataWidth'(cfg.h1.im[SampleWidth-1:0]);
            regDac0Source: regReadData = DataWidth'(cfg.dac0Source);
            regDac1Source: regReadData = DataWidth'(cfg.dac1Source);
            default:       regReadData = '0;    // Unmapped
        endcase
    end

    // Host must stay quiet while the bank is being reset
    assert property (@(posedge clk) !(regWrite && reset))
        else $error("stcRegs: host write during reset");

endmodule
